//--- compile.f
+incdir+include
design/dcache_pkg.sv
design/dcache_replace_lfsr.sv
design/dcache_tag_store.sv
design/dcache_data_store.sv
design/dcache_ctrl.sv
design/dcache_top.sv
tb/dcache_props.sv
tb/dcache_checker.sv
tb/tb_top.sv

//--- design/dcache_ctrl.sv
`timescale 1ns/100ps
`include "dcache_config.svh"

module dcache_ctrl (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  req,
	input  logic                  we,
	input  logic [`DC_ADDR_W-1:0] addr,
	input  dcache_pkg::wstrb_t    wstrb,
	input  dcache_pkg::word_t     wdata,
	output logic                  addr_ok,
	output logic                  data_ok,
	input  logic [1:0]            hit,
	input  logic                  victim_dirty,
	input  dcache_pkg::tag_t      victim_tag,
	input  logic                  victim_pick,
	output dcache_pkg::index_t    lookup_index,
	output dcache_pkg::tag_t      req_tag,
	output logic                  way_sel,
	output dcache_pkg::word_sel_t word_sel,
	output logic                  core_we,
	output dcache_pkg::wstrb_t    core_wstrb,
	output dcache_pkg::word_t     core_wdata,
	output logic                  refill_we,
	output dcache_pkg::word_sel_t refill_word,
	output logic                  tag_fill,
	output logic                  dirty_set,
	output logic                  rd_req,
	output logic [`DC_ADDR_W-1:0] rd_addr,
	output logic                  wr_req,
	output logic [`DC_ADDR_W-1:0] wr_addr,
	input  logic                  rd_rdy,
	input  logic                  wr_rdy,
	input  logic                  ret_valid,
	input  logic                  ret_last
);

	dcache_pkg::dc_state_e state_q;
	dcache_pkg::dc_state_e state_d;
	logic live;
	logic accept;
	logic hit_any;
	logic victim_way;
	dcache_pkg::word_sel_t beat_q;
	// captured request
	logic [`DC_ADDR_W-1:0] cap_addr;
	logic cap_we;
	dcache_pkg::wstrb_t cap_wstrb;
	dcache_pkg::word_t cap_wdata;

	// core port open only while no miss is in progress
	assign live    = (state_q == dcache_pkg::S_IDLE) || (state_q == dcache_pkg::S_HIT);
	assign addr_ok = live;
	assign data_ok = (state_q == dcache_pkg::S_HIT);
	assign accept  = req && addr_ok;
	assign hit_any = |hit;

	// live address while accepting, held one during a miss
	assign lookup_index = live ? addr[`DC_OFFSET_W +: `DC_INDEX_W]
		: cap_addr[`DC_OFFSET_W +: `DC_INDEX_W];
	assign req_tag  = live ? addr[`DC_ADDR_W-1 -: `DC_TAG_W] : cap_addr[`DC_ADDR_W-1 -: `DC_TAG_W];
	assign word_sel = live ? addr[`DC_OFFSET_W-1 -: 2] : cap_addr[`DC_OFFSET_W-1 -: 2];

	// hit way on lookup
	// lfsr pick in S_MISS, latched pick afterwards
	always_comb begin
		case (state_q)
			dcache_pkg::S_IDLE, dcache_pkg::S_HIT: way_sel = hit[1];
			dcache_pkg::S_MISS: way_sel = victim_pick;
			default: way_sel = victim_way;
		endcase
	end

	// write hits commit at acceptance, write misses at replay
	assign core_we    = (accept && hit_any && we) || (state_q == dcache_pkg::S_REPLAY && cap_we);
	assign core_wstrb = live ? wstrb : cap_wstrb;
	assign core_wdata = live ? wdata : cap_wdata;
	assign dirty_set  = core_we;

	// refill beats in word order, tag written with the last one
	assign refill_we   = (state_q == dcache_pkg::S_REFILL) && ret_valid;
	assign refill_word = beat_q;
	assign tag_fill    = refill_we && ret_last;

	// memory requests held by state until ready
	assign wr_req  = (state_q == dcache_pkg::S_REPLACE);
	assign rd_req  = (state_q == dcache_pkg::S_REFILL_REQ);
	assign rd_addr = {cap_addr[`DC_ADDR_W-1:`DC_OFFSET_W], {`DC_OFFSET_W{1'b0}}};
	// victim line address from its stored tag
	assign wr_addr = {victim_tag, cap_addr[`DC_OFFSET_W +: `DC_INDEX_W], {`DC_OFFSET_W{1'b0}}};

	always_comb begin
		state_d = state_q;
		case (state_q)
			dcache_pkg::S_IDLE, dcache_pkg::S_HIT: begin
				if (accept) begin
					state_d = hit_any ? dcache_pkg::S_HIT : dcache_pkg::S_MISS;
				end else begin
					state_d = dcache_pkg::S_IDLE;
				end
			end
			// clean victim skips the write-back
			dcache_pkg::S_MISS: begin
				state_d = victim_dirty ? dcache_pkg::S_REPLACE : dcache_pkg::S_REFILL_REQ;
			end
			dcache_pkg::S_REPLACE: begin
				if (wr_rdy) begin
					state_d = dcache_pkg::S_REFILL_REQ;
				end
			end
			dcache_pkg::S_REFILL_REQ: begin
				if (rd_rdy) begin
					state_d = dcache_pkg::S_REFILL;
				end
			end
			dcache_pkg::S_REFILL: begin
				if (ret_valid && ret_last) begin
					state_d = dcache_pkg::S_REPLAY;
				end
			end
			// replayed access completes as a hit
			dcache_pkg::S_REPLAY: state_d = dcache_pkg::S_HIT;
			default: state_d = dcache_pkg::S_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state_q    <= dcache_pkg::S_IDLE;
			victim_way <= 1'b0;
			beat_q     <= '0;
		end else begin
			state_q <= state_d;
			if (state_q == dcache_pkg::S_MISS) begin
				victim_way <= victim_pick;
			end
			// beat count restarts before each refill
			if (state_q == dcache_pkg::S_REFILL_REQ) begin
				beat_q <= '0;
			end else if (refill_we) begin
				beat_q <= beat_q + 2'd1;
			end
		end
	end

	// request fields held for the miss and replay
	always_ff @(posedge clk) begin
		if (accept) begin
			cap_addr  <= addr;
			cap_we    <= we;
			cap_wstrb <= wstrb;
			cap_wdata <= wdata;
		end
	end

endmodule

//--- design/dcache_data_store.sv
`timescale 1ns/100ps
`include "dcache_config.svh"

module dcache_data_store (
	input  logic                  clk,
	input  dcache_pkg::index_t    lookup_index,
	input  logic                  way_sel,
	input  dcache_pkg::word_sel_t word_sel,
	input  logic                  core_we,
	input  dcache_pkg::wstrb_t    core_wstrb,
	input  dcache_pkg::word_t     core_wdata,
	input  logic                  refill_we,
	input  dcache_pkg::word_sel_t refill_word,
	input  dcache_pkg::word_t     ret_data,
	output dcache_pkg::word_t     rd_word,
	output dcache_pkg::line_t     rd_line
);

	// two ways, four word banks each
	dcache_pkg::word_t bank_q [2][`DC_WORDS][`DC_SETS];
	logic [`DC_WORDS-1:0] core_bank;
	logic [`DC_WORDS-1:0] refill_bank;
	dcache_pkg::word_sel_t word_sel_q;

	// one-hot bank enables
	assign core_bank   = core_we ? (`DC_WORDS'(1) << word_sel) : '0;
	assign refill_bank = refill_we ? (`DC_WORDS'(1) << refill_word) : '0;

	// refill beats write whole words
	// core writes merge bytes under strobe
	always_ff @(posedge clk) begin
		for (int b = 0; b < `DC_WORDS; b++) begin
			if (refill_bank[b]) begin
				bank_q[way_sel][b][lookup_index] <= ret_data;
			end else if (core_bank[b]) begin
				for (int i = 0; i < `DC_WSTRB_W; i++) begin
					if (core_wstrb[i]) begin
						bank_q[way_sel][b][lookup_index][8*i +: 8] <= core_wdata[8*i +: 8];
					end
				end
			end
		end
	end

	// registered line read, old data on a same-edge write
	always_ff @(posedge clk) begin
		for (int b = 0; b < `DC_WORDS; b++) begin
			rd_line[`DC_DATA_W*b +: `DC_DATA_W] <= bank_q[way_sel][b][lookup_index];
		end
		word_sel_q <= word_sel;
	end

	// word picked from the held line
	assign rd_word = rd_line[`DC_DATA_W*word_sel_q +: `DC_DATA_W];

endmodule

//--- design/dcache_pkg.sv
`include "dcache_config.svh"

package dcache_pkg;

	// controller states
	typedef enum logic [2:0] {
		S_IDLE,
		S_HIT,
		S_MISS,
		S_REPLACE,
		S_REFILL_REQ,
		S_REFILL,
		S_REPLAY
	} dc_state_e;

	// address fields
	typedef logic [`DC_TAG_W-1:0] tag_t;
	typedef logic [`DC_INDEX_W-1:0] index_t;

	// data path
	typedef logic [`DC_DATA_W-1:0] word_t;
	typedef logic [`DC_WSTRB_W-1:0] wstrb_t;
	typedef logic [`DC_LINE_W-1:0] line_t;

	// word within a line
	typedef logic [1:0] word_sel_t;

endpackage

//--- design/dcache_replace_lfsr.sv
`timescale 1ns/100ps
`include "dcache_config.svh"

module dcache_replace_lfsr (
	input  logic clk,
	input  logic rst_n,
	output logic victim_pick
);

	logic [`DC_LFSR_W-1:0] lfsr_q;
	logic feedback;

	// taps 8,6,5,4, maximal length
	assign feedback = lfsr_q[7] ^ lfsr_q[5] ^ lfsr_q[4] ^ lfsr_q[3];

	// steps every cycle, hits included
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			lfsr_q <= `DC_LFSR_SEED;
		end else begin
			lfsr_q <= {lfsr_q[`DC_LFSR_W-2:0], feedback};
		end
	end

	// low bit names the way to evict
	assign victim_pick = lfsr_q[0];

endmodule

//--- design/dcache_tag_store.sv
`timescale 1ns/100ps
`include "dcache_config.svh"

module dcache_tag_store (
	input  logic               clk,
	input  logic               rst_n,
	input  dcache_pkg::index_t lookup_index,
	input  dcache_pkg::tag_t   req_tag,
	input  logic               way_sel,
	input  logic               tag_fill,
	input  logic               dirty_set,
	output logic [1:0]         hit,
	output logic               victim_dirty,
	output dcache_pkg::tag_t   victim_tag
);

	// tag array per way
	dcache_pkg::tag_t tag_q [2][`DC_SETS];
	// status bits, one vector per way
	logic [`DC_SETS-1:0] valid_q [2];
	logic [`DC_SETS-1:0] dirty_q [2];

	// tag written only on refill completion
	always_ff @(posedge clk) begin
		if (tag_fill) begin
			tag_q[way_sel][lookup_index] <= req_tag;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int w = 0; w < 2; w++) begin
				valid_q[w] <= '0;
				dirty_q[w] <= '0;
			end
		end else if (tag_fill) begin
			// fresh line, clean
			valid_q[way_sel][lookup_index] <= 1'b1;
			dirty_q[way_sel][lookup_index] <= 1'b0;
		end else if (dirty_set) begin
			dirty_q[way_sel][lookup_index] <= 1'b1;
		end
	end

	// combinational compare against both ways
	always_comb begin
		for (int w = 0; w < 2; w++) begin
			hit[w] = valid_q[w][lookup_index] && (tag_q[w][lookup_index] == req_tag);
		end
	end

	// status of the way picked for eviction
	// dirty only ever set on a valid line
	assign victim_dirty = dirty_q[way_sel][lookup_index];
	assign victim_tag   = tag_q[way_sel][lookup_index];

endmodule

//--- design/dcache_top.sv
`timescale 1ns/100ps
`include "dcache_config.svh"

module dcache_top (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  req,
	input  logic                  we,
	input  logic [`DC_ADDR_W-1:0] addr,
	input  dcache_pkg::wstrb_t    wstrb,
	input  dcache_pkg::word_t     wdata,
	output logic                  addr_ok,
	output logic                  data_ok,
	output dcache_pkg::word_t     rdata,
	output logic                  rd_req,
	input  logic                  rd_rdy,
	output logic [`DC_ADDR_W-1:0] rd_addr,
	input  logic                  ret_valid,
	input  logic                  ret_last,
	input  dcache_pkg::word_t     ret_data,
	output logic                  wr_req,
	input  logic                  wr_rdy,
	output logic [`DC_ADDR_W-1:0] wr_addr,
	output dcache_pkg::line_t     wr_data
);

	// lookup and write controls
	dcache_pkg::index_t lookup_index;
	dcache_pkg::tag_t req_tag;
	logic way_sel;
	dcache_pkg::word_sel_t word_sel;
	logic core_we;
	dcache_pkg::wstrb_t core_wstrb;
	dcache_pkg::word_t core_wdata;
	logic refill_we;
	dcache_pkg::word_sel_t refill_word;
	logic tag_fill;
	logic dirty_set;
	// tag store status
	logic [1:0] hit;
	logic victim_dirty;
	dcache_pkg::tag_t victim_tag;
	logic victim_pick;

	dcache_ctrl u_ctrl (
		.clk(clk), .rst_n(rst_n),
		.req(req), .we(we), .addr(addr), .wstrb(wstrb), .wdata(wdata),
		.addr_ok(addr_ok), .data_ok(data_ok),
		.hit(hit), .victim_dirty(victim_dirty), .victim_tag(victim_tag),
		.victim_pick(victim_pick),
		.lookup_index(lookup_index), .req_tag(req_tag), .way_sel(way_sel),
		.word_sel(word_sel), .core_we(core_we), .core_wstrb(core_wstrb),
		.core_wdata(core_wdata), .refill_we(refill_we), .refill_word(refill_word),
		.tag_fill(tag_fill), .dirty_set(dirty_set),
		.rd_req(rd_req), .rd_addr(rd_addr), .wr_req(wr_req), .wr_addr(wr_addr),
		.rd_rdy(rd_rdy), .wr_rdy(wr_rdy), .ret_valid(ret_valid), .ret_last(ret_last)
	);

	dcache_tag_store u_tag_store (
		.clk(clk), .rst_n(rst_n),
		.lookup_index(lookup_index), .req_tag(req_tag), .way_sel(way_sel),
		.tag_fill(tag_fill), .dirty_set(dirty_set),
		.hit(hit), .victim_dirty(victim_dirty), .victim_tag(victim_tag)
	);

	// rd_word feeds the core, rd_line the write-back port
	dcache_data_store u_data_store (
		.clk(clk),
		.lookup_index(lookup_index), .way_sel(way_sel), .word_sel(word_sel),
		.core_we(core_we), .core_wstrb(core_wstrb), .core_wdata(core_wdata),
		.refill_we(refill_we), .refill_word(refill_word), .ret_data(ret_data),
		.rd_word(rdata), .rd_line(wr_data)
	);

	dcache_replace_lfsr u_lfsr (
		.clk(clk), .rst_n(rst_n),
		.victim_pick(victim_pick)
	);

endmodule

//--- include/dcache_config.svh
`ifndef DCACHE_CONFIG_SVH
`define DCACHE_CONFIG_SVH

// core address and word
`define DC_ADDR_W 32
`define DC_DATA_W 32
`define DC_WSTRB_W 4

// address split: tag, index, byte offset
`define DC_TAG_W 23
`define DC_INDEX_W 5
`define DC_OFFSET_W 4

// 32 sets of two ways
`define DC_SETS 32

// four words per line, whole line on the write port
`define DC_WORDS 4
`define DC_LINE_W 128

// replacement lfsr, seed must not be zero
`define DC_LFSR_W 8
`define DC_LFSR_SEED 8'hA5

`endif

//--- run.sh
#!/bin/sh
# build the cache testbench with Verilator, run it, judge by the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --assert --top-module tb_top -f compile.f -o tb_sim \
	&& ./obj_dir/tb_sim > sim.log 2>&1 \
	|| echo "build or simulation exited with an error"
cat sim.log 2>/dev/null
grep -qx "Test OK" sim.log && echo "simulation passed" && exit 0 \
	|| { echo "simulation failed"; exit 1; }

//--- tb/dcache_checker.sv
`timescale 1ns/100ps
`include "dcache_config.svh"

module dcache_checker (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  req,
	input  logic                  we,
	input  logic [`DC_ADDR_W-1:0] addr,
	input  dcache_pkg::wstrb_t    wstrb,
	input  dcache_pkg::word_t     wdata,
	input  logic                  addr_ok,
	input  logic                  data_ok,
	input  dcache_pkg::word_t     rdata,
	input  logic                  rd_req,
	input  logic                  rd_rdy,
	input  logic [`DC_ADDR_W-1:0] rd_addr,
	input  logic                  wr_req,
	input  logic                  wr_rdy,
	input  logic [`DC_ADDR_W-1:0] wr_addr,
	input  dcache_pkg::line_t     wr_data,
	output int                    errors,
	output int                    checks,
	output int                    pending
);

	// golden copy of the first 4 KB, word addressed
	logic [31:0] gold [1024];
	// bit 32 marks a read, low bits the expected word
	logic [32:0] exp_q [$];
	logic [32:0] head;
	logic [27:0] last_line;
	logic have_last;
	logic hit_due;
	logic reset_seen;

	task automatic value_error(input string msg);
		$display("[ERROR] %0t: %s", $time, msg);
		errors++;
	endtask

	task automatic protocol_error(input string msg);
		$display("protocol failure at %0t: %s", $time, msg);
		errors++;
	endtask

	always @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < 1024; i++) begin
				gold[i] = ~(32'(i) << 2);
			end
			exp_q.delete();
			have_last = 1'b0;
			hit_due = 1'b0;
			reset_seen = 1'b0;
		end else begin
			// port status straight out of reset
			if (!reset_seen) begin
				reset_seen = 1'b1;
				checks++;
				if (!addr_ok || rd_req || wr_req || data_ok) begin
					protocol_error("port levels wrong right after reset");
				end
			end
			// same line as the access before must answer as a hit
			if (hit_due) begin
				checks++;
				if (!data_ok || rd_req) begin
					protocol_error("no hit response one cycle after a same-line access");
				end
			end
			hit_due = 1'b0;
			if (addr_ok && (rd_req || wr_req)) begin
				protocol_error("addr_ok high while a miss is in progress");
			end
			if (data_ok) begin
				if (exp_q.size() == 0) begin
					protocol_error("data_ok with no request outstanding");
				end else begin
					head = exp_q.pop_front();
					if (head[32]) begin
						checks++;
						if (rdata !== head[31:0]) begin
							value_error($sformatf("rdata %h, expected %h", rdata, head[31:0]));
						end
					end
				end
			end
			// refill fetches the line that missed
			if (rd_req && rd_rdy) begin
				checks++;
				if (rd_addr !== {last_line, 4'h0}) begin
					value_error($sformatf("rd_addr %h, expected %h", rd_addr,
						{last_line, 4'h0}));
				end
			end
			// evicted line against golden memory
			if (wr_req && wr_rdy) begin
				checks++;
				// victim sits in the set of the missing line, under another tag
				if (wr_addr[31:12] != '0 || wr_addr[3:0] != '0
					|| wr_addr[8:4] != last_line[4:0] || wr_addr[31:4] == last_line) begin
					value_error($sformatf("write-back address %h, not a victim of %h",
						wr_addr, {last_line, 4'h0}));
				end
				for (int i = 0; i < 4; i++) begin
					if (wr_data[32*i +: 32] !== gold[{wr_addr[11:4], 2'(i)}]) begin
						value_error($sformatf("write-back %h word %0d is %h, expected %h",
							wr_addr, i, wr_data[32*i +: 32], gold[{wr_addr[11:4], 2'(i)}]));
					end
				end
			end
			if (req && addr_ok) begin
				if (we) begin
					for (int b = 0; b < 4; b++) begin
						if (wstrb[b]) begin
							gold[addr[11:2]][8*b +: 8] = wdata[8*b +: 8];
						end
					end
					exp_q.push_back({1'b0, 32'h0});
				end else begin
					exp_q.push_back({1'b1, gold[addr[11:2]]});
				end
				hit_due = have_last && (addr[31:4] == last_line);
				last_line = addr[31:4];
				have_last = 1'b1;
			end
			pending = exp_q.size();
		end
	end

endmodule

//--- tb/dcache_props.sv
`timescale 1ns/100ps
`include "dcache_config.svh"

module dcache_props (
	input logic                  clk,
	input logic                  rst_n,
	input dcache_pkg::dc_state_e state,
	input logic                  req,
	input logic [1:0]            hit,
	input logic                  addr_ok,
	input logic                  data_ok,
	input logic                  rd_req,
	input logic                  rd_rdy,
	input logic [`DC_ADDR_W-1:0] rd_addr,
	input logic                  wr_req,
	input logic                  wr_rdy,
	input logic [`DC_ADDR_W-1:0] wr_addr
);

	// failed assertions, summed up by the testbench
	int fails;

	// refill request held until taken
	assert property (@(posedge clk) disable iff (!rst_n)
		rd_req && !rd_rdy |=> rd_req && $stable(rd_addr))
		else begin
			$error("rd_req or rd_addr changed before rd_rdy");
			fails++;
		end

	// write-back held until taken
	assert property (@(posedge clk) disable iff (!rst_n)
		wr_req && !wr_rdy |=> wr_req && $stable(wr_addr))
		else begin
			$error("wr_req or wr_addr changed before wr_rdy");
			fails++;
		end

	// hit or replay answered in the next cycle
	assert property (@(posedge clk) disable iff (!rst_n)
		(state == dcache_pkg::S_REPLAY || (req && addr_ok && |hit)) |=> data_ok)
		else begin
			$error("data_ok missing one cycle after a hit or a replay");
			fails++;
		end

	// no answer without a hit or a replay just before
	assert property (@(posedge clk) disable iff (!rst_n)
		data_ok |-> $past(state == dcache_pkg::S_REPLAY || (req && addr_ok && |hit)))
		else begin
			$error("data_ok without a hit or a replay before it");
			fails++;
		end

	// core port shut from a miss until its replay
	assert property (@(posedge clk) disable iff (!rst_n)
		((req && addr_ok && !(|hit)) || (!addr_ok && state != dcache_pkg::S_REPLAY))
		|=> !addr_ok)
		else begin
			$error("addr_ok reopened before the miss was replayed");
			fails++;
		end

	// no response straight out of reset
	assert property (@(posedge clk) !rst_n |=> !data_ok)
		else begin
			$error("data_ok high right after reset");
			fails++;
		end

endmodule

bind dcache_ctrl dcache_props u_props (
	.clk(clk), .rst_n(rst_n), .state(state_q), .req(req), .hit(hit),
	.addr_ok(addr_ok), .data_ok(data_ok),
	.rd_req(rd_req), .rd_rdy(rd_rdy), .rd_addr(rd_addr),
	.wr_req(wr_req), .wr_rdy(wr_rdy), .wr_addr(wr_addr)
);

//--- tb/tb_top.sv
`timescale 1ns/100ps
`include "dcache_config.svh"

module tb_top;

	localparam int TIMEOUT = 2000;

	logic clk = 1'b0;
	logic rst_n = 1'b0;
	// core side
	logic req = 1'b0;
	logic we = 1'b0;
	logic [`DC_ADDR_W-1:0] addr = '0;
	dcache_pkg::wstrb_t wstrb = '0;
	dcache_pkg::word_t wdata = '0;
	logic addr_ok;
	logic data_ok;
	dcache_pkg::word_t rdata;
	// memory side
	logic rd_req;
	logic rd_rdy = 1'b0;
	logic [`DC_ADDR_W-1:0] rd_addr;
	logic ret_valid = 1'b0;
	logic ret_last = 1'b0;
	dcache_pkg::word_t ret_data = '0;
	logic wr_req;
	logic wr_rdy = 1'b0;
	logic [`DC_ADDR_W-1:0] wr_addr;
	dcache_pkg::line_t wr_data;
	// memory responder state
	logic [31:0] mem [1024];
	logic [7:0] refill_base;
	logic [2:0] beat;
	logic refill_on;
	logic rd_fire;
	logic stall = 1'b0;
	logic timed_out = 1'b0;
	integer seed = 31;
	integer mem_seed = 31;
	int errors;
	int checks;
	int pending;
	int errs_before = 0;

	dcache_top u_dut (
		.clk, .rst_n, .req, .we, .addr, .wstrb, .wdata, .addr_ok, .data_ok, .rdata,
		.rd_req, .rd_rdy, .rd_addr, .ret_valid, .ret_last, .ret_data,
		.wr_req, .wr_rdy, .wr_addr, .wr_data
	);

	dcache_checker u_chk (
		.clk, .rst_n, .req, .we, .addr, .wstrb, .wdata, .addr_ok, .data_ok, .rdata,
		.rd_req, .rd_rdy, .rd_addr, .wr_req, .wr_rdy, .wr_addr, .wr_data,
		.errors, .checks, .pending
	);

	always #5 clk = ~clk;

	// memory responder, everything driven on the falling edge
	always @(negedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < 1024; i++) begin
				mem[i] = ~(32'(i) << 2);
			end
			refill_on = 1'b0;
			rd_fire = 1'b0;
			beat = '0;
		end else begin
			// beat driven half a cycle ago was taken at the edge
			if (ret_valid) begin
				beat = beat + 3'd1;
			end
			if (ret_valid && ret_last) begin
				refill_on = 1'b0;
			end
			if (rd_fire) begin
				refill_on = 1'b1;
				beat = '0;
			end
			// long low stretches under back-pressure
			rd_rdy = stall ? (($random(mem_seed) & 15) == 0) : (($random(mem_seed) & 3) != 0);
			wr_rdy = stall ? (($random(mem_seed) & 15) == 0) : (($random(mem_seed) & 3) != 0);
			// line transfers at the coming edge
			if (wr_req && wr_rdy) begin
				for (int i = 0; i < 4; i++) begin
					mem[{wr_addr[11:4], 2'(i)}] = wr_data[32*i +: 32];
				end
			end
			rd_fire = rd_req && rd_rdy;
			if (rd_fire) begin
				refill_base = rd_addr[11:4];
			end
			// random gaps between beats
			ret_valid = refill_on && (($random(mem_seed) & 3) != 0);
			ret_last = ret_valid && (beat == 3'd3);
			ret_data = ret_valid ? mem[{refill_base, beat[1:0]}] : '0;
		end
	end

	// a stuck wait ends the remaining tests
	task automatic note_timeout(input string msg);
		$display("timeout at %0t: %s", $time, msg);
		timed_out = 1'b1;
	endtask

	function automatic logic [31:0] rand_addr();
		return {20'h0, 10'($random(seed)), 2'b00};
	endfunction

	// called at a falling edge, returns at the one after acceptance
	task automatic access(input logic w, input logic [31:0] a, input dcache_pkg::wstrb_t s,
		input dcache_pkg::word_t d);
		int t;
		if (timed_out) begin
			return;
		end
		req = 1'b1;
		we = w;
		addr = a;
		wstrb = s;
		wdata = d;
		t = 0;
		while (!addr_ok && !timed_out) begin
			@(negedge clk);
			t++;
			if (t > TIMEOUT) begin
				note_timeout("addr_ok never came back for a core request");
			end
		end
		@(negedge clk);
		req = 1'b0;
	endtask

	task automatic random_access(input logic [31:0] a);
		if (($random(seed) & 1) != 0) begin
			access(1'b1, a, 4'($random(seed)), $random(seed));
		end else begin
			access(1'b0, a, 4'h0, 32'h0);
		end
	endtask

	// every accepted request answered
	task automatic drain();
		int t;
		t = 0;
		while (pending != 0 && !timed_out) begin
			@(negedge clk);
			t++;
			if (t > TIMEOUT) begin
				note_timeout("data_ok missing for an accepted request");
			end
		end
	endtask

	task automatic finish_test(input string name);
		drain();
		$display("%s: %0d errors", name, errors - errs_before);
		errs_before = errors;
	endtask

	initial begin
		logic [31:0] a;
		repeat (3) @(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);
		finish_test("reset");
		repeat (300) begin
			access(1'b0, rand_addr(), 4'h0, 32'h0);
		end
		finish_test("random reads");
		repeat (400) begin
			random_access(rand_addr());
		end
		finish_test("mixed writes and reads");
		// second access of each pair must hit
		repeat (100) begin
			a = rand_addr();
			random_access(a);
			access(1'b0, a, 4'h0, 32'h0);
		end
		finish_test("back-to-back hits");
		stall = 1'b1;
		repeat (150) begin
			random_access(rand_addr());
		end
		finish_test("back-pressure");
		stall = 1'b0;
		$display("checks %0d, errors %0d, assertion failures %0d", checks, errors,
			u_dut.u_ctrl.u_props.fails);
		if (!timed_out && errors == 0 && u_dut.u_ctrl.u_props.fails == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule
